/* ib_cfg.svh */
`ifndef IB_CFG_SVH
`define IB_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction buffer sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// total entries over both banks
`define IB_DEPTH 16

// each bank holds half of the buffer
`define IB_BANK_DEPTH 8

// one below the depth so a whole fetch pair always fits when not full
`define IB_FULL_LEVEL 15

// addi x0, x0, 0 fills dispatch slots with nothing to deliver
`define IB_NOP 32'h00000013

`endif

/* ib_pkg.sv */
`default_nettype none

package ib_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction slots
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one instruction as it moves from fetch through to dispatch
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } insn_slot_t;

    // slot0 is always the older of the two
    typedef struct packed {
        insn_slot_t slot0;
        insn_slot_t slot1;
    } insn_pair_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bank write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic       push;
        insn_slot_t slot;
    } bank_wr_t;

endpackage

`default_nettype wire

/* ib_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ib_cfg.svh"

module ib_bank #(
    parameter int DEPTH = `IB_BANK_DEPTH
) (
    input  wire                          clock,
    input  wire                          arst_n,
    input  wire                          squash,
    input  wire ib_pkg::bank_wr_t        wr,
    input  wire                          pop,
    output ib_pkg::insn_slot_t           head,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ib_pkg::insn_slot_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count_q;

    assign head  = mem[rd_ptr];
    assign count = count_q;

    // storage only changes on an accepted push
    always_ff @(posedge clock) begin
        if (wr.push && !squash) begin
            mem[wr_ptr] <= wr.slot;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count_q <= '0;
        end else if (squash) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (wr.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr.push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // the steer block keeps the total below full, so each bank must have room
    a_no_push_full: assert property (
        @(posedge clock) disable iff (!arst_n || squash)
        wr.push |-> (count_q < CNT_W'(DEPTH))
    ) else $error("push into a full bank");

    a_no_pop_empty: assert property (
        @(posedge clock) disable iff (!arst_n || squash)
        pop |-> (count_q != '0)
    ) else $error("pop from an empty bank");

endmodule

`default_nettype wire

/* ib_enq_steer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ib_cfg.svh"

module ib_enq_steer (
    input  wire                                      clock,
    input  wire                                      arst_n,
    input  wire                                      squash,
    input  wire ib_pkg::insn_pair_t                  fetch_pair,
    input  wire [$clog2(`IB_BANK_DEPTH+1)-1:0]       count_even,
    input  wire [$clog2(`IB_BANK_DEPTH+1)-1:0]       count_odd,
    output logic                                     buffer_full,
    output ib_pkg::bank_wr_t                         wr_even,
    output ib_pkg::bank_wr_t                         wr_odd
);

    localparam int TOT_W = $clog2(`IB_DEPTH + 1);

    logic [TOT_W-1:0] total;
    logic             tail_par;
    logic             push0;
    logic             push1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fullness
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign total       = TOT_W'(count_even) + TOT_W'(count_odd);
    assign buffer_full = (total >= TOT_W'(`IB_FULL_LEVEL));

    // a full buffer drops the whole pair and fetch holds it
    assign push0 = fetch_pair.slot0.valid && !buffer_full;
    assign push1 = fetch_pair.slot1.valid && !buffer_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // slot0 lands in the tail bank and slot1 in the other one
    always_comb begin
        if (tail_par) begin
            wr_odd.push  = push0;
            wr_odd.slot  = fetch_pair.slot0;
            wr_even.push = push1;
            wr_even.slot = fetch_pair.slot1;
        end else begin
            wr_even.push = push0;
            wr_even.slot = fetch_pair.slot0;
            wr_odd.push  = push1;
            wr_odd.slot  = fetch_pair.slot1;
        end
    end

    // one slot written flips the parity, two bring it back
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tail_par <= 1'b0;
        end else if (squash) begin
            tail_par <= 1'b0;
        end else begin
            tail_par <= tail_par ^ (push0 ^ push1);
        end
    end

    a_slot_order: assert property (
        @(posedge clock) disable iff (!arst_n)
        fetch_pair.slot1.valid |-> fetch_pair.slot0.valid
    ) else $error("fetch slot1 valid without slot0");

endmodule

`default_nettype wire

/* ib_dispatch_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ib_cfg.svh"

module ib_dispatch_align (
    input  wire                                      clock,
    input  wire                                      arst_n,
    input  wire                                      squash,
    input  wire [1:0]                                dp_req,
    input  wire ib_pkg::insn_slot_t                  head_even,
    input  wire ib_pkg::insn_slot_t                  head_odd,
    input  wire [$clog2(`IB_BANK_DEPTH+1)-1:0]       count_even,
    input  wire [$clog2(`IB_BANK_DEPTH+1)-1:0]       count_odd,
    output logic                                     pop_even,
    output logic                                     pop_odd,
    output ib_pkg::insn_pair_t                       dp_pair
);

    localparam int TOT_W = $clog2(`IB_DEPTH + 1);

    logic [TOT_W-1:0]   total;
    logic [1:0]         n_deliver;
    logic               head_par;
    ib_pkg::insn_slot_t older;
    ib_pkg::insn_slot_t younger;
    ib_pkg::insn_slot_t nop_slot;

    assign total = TOT_W'(count_even) + TOT_W'(count_odd);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // delivery count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // smaller of the request and what the banks hold together
    always_comb begin
        if (total == '0) begin
            n_deliver = 2'd0;
        end else if (total == TOT_W'(1)) begin
            n_deliver = (dp_req == 2'd0) ? 2'd0 : 2'd1;
        end else begin
            n_deliver = (dp_req > 2'd2) ? 2'd2 : dp_req;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ordering and padding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign nop_slot.valid = 1'b0;
    assign nop_slot.pc    = '0;
    assign nop_slot.inst  = `IB_NOP;

    // the head parity names the bank holding the oldest entry
    assign older   = head_par ? head_odd  : head_even;
    assign younger = head_par ? head_even : head_odd;

    always_comb begin
        dp_pair.slot0 = (n_deliver != 2'd0) ? older   : nop_slot;
        dp_pair.slot1 = (n_deliver == 2'd2) ? younger : nop_slot;
    end

    // a pair drains both banks, a single drains only the head bank
    always_comb begin
        case (n_deliver)
            2'd1: begin
                pop_even = !head_par;
                pop_odd  = head_par;
            end
            2'd2: begin
                pop_even = 1'b1;
                pop_odd  = 1'b1;
            end
            default: begin
                pop_even = 1'b0;
                pop_odd  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head_par <= 1'b0;
        end else if (squash) begin
            head_par <= 1'b0;
        end else begin
            head_par <= head_par ^ n_deliver[0];
        end
    end

    a_req_range: assert property (
        @(posedge clock) disable iff (!arst_n)
        dp_req <= 2'd2
    ) else $error("dispatch request above two");

    // interleaving must keep the younger bank stocked whenever two are delivered
    a_pop_nonempty: assert property (
        @(posedge clock) disable iff (!arst_n)
        (pop_even |-> count_even != '0) and (pop_odd |-> count_odd != '0)
    ) else $error("pop issued to an empty bank");

endmodule

`default_nettype wire

/* insn_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ib_cfg.svh"

module insn_buffer (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire                      squash,
    input  wire ib_pkg::insn_pair_t  fetch_pair,
    input  wire [1:0]                dp_req,
    output logic                     buffer_full,
    output ib_pkg::insn_pair_t       dp_pair
);

    localparam int CNT_W = $clog2(`IB_BANK_DEPTH + 1);

    ib_pkg::bank_wr_t   wr_even;
    ib_pkg::bank_wr_t   wr_odd;
    ib_pkg::insn_slot_t head_even;
    ib_pkg::insn_slot_t head_odd;
    logic [CNT_W-1:0]   count_even;
    logic [CNT_W-1:0]   count_odd;
    logic               pop_even;
    logic               pop_odd;

    ib_enq_steer u_enq_steer (
        .clock       (clock),
        .arst_n      (arst_n),
        .squash      (squash),
        .fetch_pair  (fetch_pair),
        .count_even  (count_even),
        .count_odd   (count_odd),
        .buffer_full (buffer_full),
        .wr_even     (wr_even),
        .wr_odd      (wr_odd)
    );

    // even bank holds global positions 0, 2, 4 and so on
    ib_bank #(.DEPTH(`IB_BANK_DEPTH)) u_bank_even (
        .clock  (clock),
        .arst_n (arst_n),
        .squash (squash),
        .wr     (wr_even),
        .pop    (pop_even),
        .head   (head_even),
        .count  (count_even)
    );

    ib_bank #(.DEPTH(`IB_BANK_DEPTH)) u_bank_odd (
        .clock  (clock),
        .arst_n (arst_n),
        .squash (squash),
        .wr     (wr_odd),
        .pop    (pop_odd),
        .head   (head_odd),
        .count  (count_odd)
    );

    ib_dispatch_align u_dispatch_align (
        .clock      (clock),
        .arst_n     (arst_n),
        .squash     (squash),
        .dp_req     (dp_req),
        .head_even  (head_even),
        .head_odd   (head_odd),
        .count_even (count_even),
        .count_odd  (count_odd),
        .pop_even   (pop_even),
        .pop_odd    (pop_odd),
        .dp_pair    (dp_pair)
    );

endmodule

`default_nettype wire

/* tb_insn_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ib_cfg.svh"

module tb_insn_buffer;

    localparam int RESET_LEN   = 3;
    localparam int T1_LEN      = 9;
    localparam int T2_LEN      = 2000;
    localparam int T3_LEN      = 25;
    localparam int T4_LEN      = 40;
    localparam int T5_LEN      = 1000;
    localparam int CYCLE_LIMIT =
        2 * (RESET_LEN + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN);

    logic               clock;
    logic               arst_n;
    logic               squash;
    ib_pkg::insn_pair_t fetch_pair;
    logic [1:0]         dp_req;
    logic               buffer_full;
    ib_pkg::insn_pair_t dp_pair;

    // the front of the reference queue is the oldest instruction in the buffer
    ib_pkg::insn_slot_t model_q[$];
    ib_pkg::insn_slot_t nop_slot;
    logic [31:0]        next_pc;
    logic [31:0]        first_pc;
    logic               after_squash;
    logic               exp_full;
    logic               saw_full;
    int                 deliver_n;
    int                 cycle_cnt = 0;
    int                 checks;
    int                 errors;

    insn_buffer u_dut (
        .clock       (clock),
        .arst_n      (arst_n),
        .squash      (squash),
        .fetch_pair  (fetch_pair),
        .dp_req      (dp_req),
        .buffer_full (buffer_full),
        .dp_pair     (dp_pair)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, the tests did not reach their end", cycle_cnt);
        $display(">>> FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // outputs are combinational from state and dp_req, so they are settled at the falling edge
    task automatic check_outputs();
        ib_pkg::insn_slot_t exp0;
        ib_pkg::insn_slot_t exp1;
        exp_full  = (model_q.size() >= `IB_FULL_LEVEL);
        deliver_n = (int'(dp_req) < model_q.size()) ? int'(dp_req) : model_q.size();
        exp0 = (deliver_n >= 1) ? model_q[0] : nop_slot;
        exp1 = (deliver_n >= 2) ? model_q[1] : nop_slot;
        if (buffer_full === 1'b1) begin
            saw_full = 1'b1;
        end
        checks += 3;
        assert (buffer_full === exp_full) else begin
            errors++;
            $display("Mismatch buffer_full: got %h expected %h", buffer_full, exp_full);
        end
        assert (dp_pair.slot0 === exp0) else begin
            errors++;
            $display("Mismatch dp_pair.slot0: got %h expected %h", dp_pair.slot0, exp0);
        end
        assert (dp_pair.slot1 === exp1) else begin
            errors++;
            $display("Mismatch dp_pair.slot1: got %h expected %h", dp_pair.slot1, exp1);
        end
        // the first instruction out after a squash must be the first one fetched after it
        if (after_squash && deliver_n >= 1) begin
            checks++;
            after_squash = 1'b0;
            assert (dp_pair.slot0.pc === first_pc) else begin
                errors++;
                $display("Mismatch dp_pair.slot0.pc: got %h expected %h",
                         dp_pair.slot0.pc, first_pc);
            end
        end
    endtask

    // the model applies squash, dequeue and enqueue in the order the next edge does
    task automatic update_model();
        if (squash) begin
            model_q.delete();
            after_squash = 1'b1;
            first_pc     = next_pc;
        end else begin
            for (int i = 0; i < deliver_n; i++) begin
                void'(model_q.pop_front());
            end
            if (!exp_full) begin
                if (fetch_pair.slot0.valid) begin
                    model_q.push_back(fetch_pair.slot0);
                end
                if (fetch_pair.slot1.valid) begin
                    model_q.push_back(fetch_pair.slot1);
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_cycle(input int nfetch, input logic [1:0] req, input logic sq);
        ib_pkg::insn_pair_t pair;
        pair = '0;
        if (nfetch >= 1) begin
            pair.slot0.valid = 1'b1;
            pair.slot0.pc    = next_pc;
            pair.slot0.inst  = $urandom;
            next_pc          = next_pc + 32'd4;
        end
        if (nfetch >= 2) begin
            pair.slot1.valid = 1'b1;
            pair.slot1.pc    = next_pc;
            pair.slot1.inst  = $urandom;
            next_pc          = next_pc + 32'd4;
        end
        @(posedge clock);
        fetch_pair <= pair;
        dp_req     <= req;
        squash     <= sq;
        @(negedge clock);
        check_outputs();
        update_model();
    endtask

    task automatic fill_entries(input int count);
        int left;
        left = count;
        while (left > 0) begin
            run_cycle((left >= 2) ? 2 : 1, 2'd0, 1'b0);
            left -= (left >= 2) ? 2 : 1;
        end
    endtask

    // one extra cycle shows the empty buffer padding both slots
    task automatic drain_buffer();
        while (model_q.size() != 0) begin
            run_cycle(0, 2'd2, 1'b0);
        end
        run_cycle(0, 2'd2, 1'b0);
    endtask

    task automatic finish_test(input int num, input string name, input int err_before);
        $display("test %0d %s finished with %0d errors", num, name, errors - err_before);
    endtask

    initial begin
        int err0;
        void'($urandom(32'hf4e6));
        arst_n         = 1'b0;
        squash         = 1'b0;
        dp_req         = 2'd0;
        fetch_pair     = '0;
        next_pc        = 32'h0000_1000;
        first_pc       = '0;
        after_squash   = 1'b0;
        saw_full       = 1'b0;
        exp_full       = 1'b0;
        deliver_n      = 0;
        checks         = 0;
        errors         = 0;
        nop_slot.valid = 1'b0;
        nop_slot.pc    = '0;
        nop_slot.inst  = `IB_NOP;
        repeat (RESET_LEN) @(posedge clock);
        arst_n <= 1'b1;

        err0 = errors;
        for (int i = 0; i < T1_LEN; i++) begin
            run_cycle(0, 2'(i % 3), 1'b0);
        end
        finish_test(1, "idle after reset", err0);

        err0 = errors;
        for (int i = 0; i < T2_LEN; i++) begin
            run_cycle($urandom % 3, 2'($urandom % 3), 1'b0);
        end
        finish_test(2, "random traffic", err0);

        // start the fill from an empty buffer
        err0     = errors;
        saw_full = 1'b0;
        run_cycle(0, 2'd0, 1'b1);
        for (int i = 0; i < T3_LEN - 1; i++) begin
            run_cycle(1 + ($urandom % 2), 2'd0, 1'b0);
        end
        checks++;
        assert (saw_full) else begin
            errors++;
            $display("buffer never reported full during the fill phase");
        end
        finish_test(3, "fill to full", err0);

        // an odd fill flips the head parity so the next drain starts on the other bank
        err0 = errors;
        drain_buffer();
        fill_entries(5);
        drain_buffer();
        fill_entries(6);
        drain_buffer();
        finish_test(4, "drain in order", err0);

        err0 = errors;
        for (int i = 0; i < T5_LEN; i++) begin
            run_cycle($urandom % 3, 2'($urandom % 3), (($urandom % 32) == 0));
        end
        finish_test(5, "random squash", err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
ib_pkg.sv
ib_bank.sv
ib_enq_steer.sv
ib_dispatch_align.sv
insn_buffer.sv
tb_insn_buffer.sv

/* Bender.yml */
package:
  name: insn_buffer

export_include_dirs:
  - .

sources:
  - files:
      - ib_pkg.sv
      - ib_bank.sv
      - ib_enq_steer.sv
      - ib_dispatch_align.sv
      - insn_buffer.sv
  - target: test
    files:
      - tb_insn_buffer.sv
